// ==== verif/exec_stimulus.mem ====
// columns: inst pc rdata rd wdata nextpc flags
// flags: bit0 illegal, bit1 register write expected
00500093 1000 0 01 0000000000000005 1004 2
80000137 1004 0 02 ffffffff80000000 1008 2
ffd00193 1008 0 03 fffffffffffffffd 100c 2
00308233 100c 0 04 0000000000000002 1010 2
401202b3 1010 0 05 fffffffffffffffd 1014 2
0022c333 1014 0 06 000000007ffffffd 1018 2
001373b3 1018 0 07 0000000000000005 101c 2
00116433 101c 0 08 ffffffff80000005 1020 2
0011a4b3 1020 0 09 0000000000000001 1024 2
0011b533 1024 0 0a 0000000000000000 1028 2
// shifts and word forms
001095b3 1028 0 0b 00000000000000a0 102c 2
02415613 102c 0 0c 000000000fffffff 1030 2
40415693 1030 0 0d fffffffff8000000 1034 2
0011973b 1034 0 0e ffffffffffffffa0 1038 2
0011d7bb 1038 0 0f 0000000007ffffff 103c 2
4014583b 103c 0 10 fffffffffc000000 1040 2
001308bb 1040 0 11 ffffffff80000002 1044 2
// multiply, divide, remainder
02118933 1044 0 12 fffffffffffffff1 1048 2
021949b3 1048 0 13 fffffffffffffffd 104c 2
0200da33 104c 0 14 ffffffffffffffff 1050 2
0201eab3 1050 0 15 fffffffffffffffd 1054 2
02197b33 1054 0 16 0000000000000001 1058 2
03fa1b93 1058 0 17 8000000000000000 105c 2
034bcc33 105c 0 18 8000000000000000 1060 2
034becb3 1060 0 19 0000000000000000 1064 2
// branches and jumps
00708863 1064 0 00 0000000000000000 1074 0
00709863 1068 0 00 0000000000000000 106c 0
fe11cce3 106c 0 00 0000000000000000 1064 0
fe11fce3 1070 0 00 0000000000000000 1068 0
0011d863 1074 0 00 0000000000000000 1078 0
10000d6f 1078 0 1a 000000000000107c 1178 2
007d0de7 107c 0 1b 0000000000001080 1082 2
// loads
00000e03 1080 0123456789abcdef 1c ffffffffffffffef 1084 2
00004e03 1084 0123456789abcdef 1c 00000000000000ef 1088 2
00001e03 1088 0123456789abcdef 1c ffffffffffffcdef 108c 2
00005e03 108c 0123456789abcdef 1c 000000000000cdef 1090 2
00002e03 1090 0123456789abcdef 1c ffffffff89abcdef 1094 2
00006e03 1094 0123456789abcdef 1c 0000000089abcdef 1098 2
00003e03 1098 0123456789abcdef 1c 0123456789abcdef 109c 2
// illegal encodings, then a read of x1
000000ff 109c 0 01 0000000000000000 10a0 1
021090b3 10a0 0 01 0000000000000000 10a4 1
00008f93 10a4 0 1f 0000000000000005 10a8 2

// ==== verilog.f ====
common/exec_pkg.sv
idu/idu_decode.sv
hdl/gpr_file.sv
exu/exu_alu.sv
exu/exu_execute.sv
hdl/wbu_commit.sv
hdl/exec_top.sv
verif/tb_exec_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the execute path testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f verilog.f --top-module tb_exec_top -o sim_exec_top
out=$(./obj_dir/sim_exec_top) || true
echo "$out"
if echo "$out" | grep -qx "ALL TESTS PASSED"; then
  exit 0
fi
exit 1

// ==== verif/tb_exec_top.sv ====
// testbench for exec_top: file driven instruction stream, in-order commit checks
`timescale 1ns/10ps
module tb_exec_top;
  import exec_pkg::*;

  localparam int NUM_TESTS      = 42;
  localparam int NUM_COLS       = 7;
  localparam int TIMEOUT_CYCLES = 200;

  logic            clk;
  logic            rst_n;
  logic            valid;
  logic [ILEN-1:0] inst;
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] rdata;
  logic            commit_valid;
  commit_t         commit;

  // inst, pc, rdata, rd, wdata, nextpc, flags per instruction
  logic [63:0] stim [0:NUM_TESTS*NUM_COLS-1];

  int commit_idx = 0;
  int pass_cnt   = 0;
  int fail_cnt   = 0;
  int extra_cnt  = 0;

  exec_top dut_i (
    .i_clk          (clk),
    .i_rst_n        (rst_n),
    .i_valid        (valid),
    .i_inst         (inst),
    .i_pc           (pc),
    .i_rdata        (rdata),
    .o_commit_valid (commit_valid),
    .o_commit       (commit)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_commit(input int idx);
    logic [63:0] exp_pc;
    logic [63:0] exp_rd;
    logic [63:0] exp_wdata;
    logic [63:0] exp_nextpc;
    logic [63:0] flags;
    int          errs;
    exp_pc     = stim[idx*NUM_COLS+1];
    exp_rd     = stim[idx*NUM_COLS+3];
    exp_wdata  = stim[idx*NUM_COLS+4];
    exp_nextpc = stim[idx*NUM_COLS+5];
    flags      = stim[idx*NUM_COLS+6];
    errs       = 0;
    if (commit.pc != exp_pc) begin
      $display("FAILED t=%0t o_commit.pc expected %h got %h", $time, exp_pc, commit.pc);
      errs++;
    end
    if (commit.nextpc != exp_nextpc) begin
      $display("FAILED t=%0t o_commit.nextpc expected %h got %h",
               $time, exp_nextpc, commit.nextpc);
      errs++;
    end
    if (commit.illegal != flags[0]) begin
      $display("FAILED t=%0t o_commit.illegal expected %b got %b",
               $time, flags[0], commit.illegal);
      errs++;
    end
    if (commit.reg_write != flags[1]) begin
      $display("FAILED t=%0t o_commit.reg_write expected %b got %b",
               $time, flags[1], commit.reg_write);
      errs++;
    end
    // rd and wdata only mean something when a register is written
    if (flags[1] && commit.rd != exp_rd[REG_AW-1:0]) begin
      $display("FAILED t=%0t o_commit.rd expected %0d got %0d",
               $time, exp_rd[REG_AW-1:0], commit.rd);
      errs++;
    end
    if (flags[1] && commit.wdata != exp_wdata) begin
      $display("FAILED t=%0t o_commit.wdata expected %h got %h",
               $time, exp_wdata, commit.wdata);
      errs++;
    end
    if (errs == 0) begin
      pass_cnt++;
      $display("test %0d pc %0h passed", idx, exp_pc);
    end else begin
      fail_cnt++;
      $display("test %0d pc %0h failed with %0d mismatches", idx, exp_pc, errs);
    end
  endtask

  // commits are compared in program order
  always @(negedge clk) begin
    if (commit_valid) begin
      if (commit_idx < NUM_TESTS) begin
        check_commit(commit_idx);
        commit_idx++;
      end else begin
        $display("unexpected commit after the last instruction at t=%0t", $time);
        extra_cnt++;
      end
    end
  end

  initial begin
    int   wait_cycles;
    logic timed_out;
    rst_n     = 1'b0;
    valid     = 1'b0;
    inst      = '0;
    pc        = '0;
    rdata     = '0;
    timed_out = 1'b0;
    $readmemh("verif/exec_stimulus.mem", stim);
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // one instruction per cycle, back to back
    for (int i = 0; i < NUM_TESTS; i++) begin
      @(posedge clk);
      #1;
      valid = 1'b1;
      inst  = stim[i*NUM_COLS][ILEN-1:0];
      pc    = stim[i*NUM_COLS+1];
      rdata = stim[i*NUM_COLS+2];
    end
    @(posedge clk);
    #1;
    valid = 1'b0;
    wait_cycles = 0;
    while (commit_idx < NUM_TESTS && wait_cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (commit_idx < NUM_TESTS) begin
      timed_out = 1'b1;
      $display("timeout: only %0d of %0d instructions committed", commit_idx, NUM_TESTS);
    end else begin
      // idle cycles to catch stray commits
      repeat (4) @(posedge clk);
    end
    $display("tests: %0d run, %0d passed, %0d failed, %0d unexpected commits",
             commit_idx, pass_cnt, fail_cnt, extra_cnt);
    if (!timed_out && fail_cnt == 0 && extra_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== hdl/exec_top.sv ====
// execute path top: decoder, register file, execute unit, commit stage
`timescale 1ns/10ps
module exec_top (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  logic                      i_valid,
  input  logic [exec_pkg::ILEN-1:0] i_inst,
  input  logic [exec_pkg::XLEN-1:0] i_pc,
  input  logic [exec_pkg::XLEN-1:0] i_rdata,
  output logic                      o_commit_valid,
  output exec_pkg::commit_t         o_commit
);
  import exec_pkg::*;

  dec_req_t          dec_req;
  ex_res_t           ex_res;
  logic [REG_AW-1:0] rs1;
  logic [REG_AW-1:0] rs2;
  logic [XLEN-1:0]   rs1_data;
  logic [XLEN-1:0]   rs2_data;
  logic              gpr_we;
  logic [REG_AW-1:0] gpr_wa;
  logic [XLEN-1:0]   gpr_wd;

  idu_decode idu_i (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_valid (i_valid),
    .i_inst  (i_inst),
    .i_pc    (i_pc),
    .i_rdata (i_rdata),
    .o_req   (dec_req)
  );

  gpr_file gpr_i (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_we       (gpr_we),
    .i_wa       (gpr_wa),
    .i_wd       (gpr_wd)
  );

  exu_execute exu_i (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_req      (dec_req),
    .o_rs1      (rs1),
    .o_rs2      (rs2),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .o_res      (ex_res)
  );

  wbu_commit wbu_i (
    .i_res          (ex_res),
    .o_we           (gpr_we),
    .o_wa           (gpr_wa),
    .o_wd           (gpr_wd),
    .o_commit_valid (o_commit_valid),
    .o_commit       (o_commit)
  );

endmodule

// ==== hdl/wbu_commit.sv ====
// commit stage: register write port and retired instruction record
`timescale 1ns/10ps
module wbu_commit (
  input  exec_pkg::ex_res_t           i_res,
  output logic                        o_we,
  output logic [exec_pkg::REG_AW-1:0] o_wa,
  output logic [exec_pkg::XLEN-1:0]   o_wd,
  output logic                        o_commit_valid,
  output exec_pkg::commit_t           o_commit
);

  // x0 and illegal instructions never reach the register file
  assign o_we = i_res.valid && i_res.reg_write && !i_res.illegal && (i_res.rd != '0);
  assign o_wa = i_res.rd;
  assign o_wd = i_res.wdata;

  assign o_commit_valid = i_res.valid;

  always_comb begin
    o_commit.pc        = i_res.pc;
    o_commit.nextpc    = i_res.nextpc;
    o_commit.rd        = i_res.rd;
    o_commit.wdata     = i_res.wdata;
    o_commit.reg_write = i_res.reg_write;
    o_commit.illegal   = i_res.illegal;
  end

  // decode already drops reg_write for illegal encodings
  always_comb begin
    if (i_res.valid && i_res.illegal) begin
      a_illegal_no_write: assert (!i_res.reg_write)
        else $error("illegal commit carries a register write");
    end
  end

endmodule

// ==== exu/exu_execute.sv ====
// execute stage: operand select, branch decision, next pc, load extension
`timescale 1ns/10ps
module exu_execute (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  exec_pkg::dec_req_t          i_req,
  output logic [exec_pkg::REG_AW-1:0] o_rs1,
  output logic [exec_pkg::REG_AW-1:0] o_rs2,
  input  logic [exec_pkg::XLEN-1:0]   i_rs1_data,
  input  logic [exec_pkg::XLEN-1:0]   i_rs2_data,
  output exec_pkg::ex_res_t           o_res
);
  import exec_pkg::*;

  ctrl_t           ctrl;
  logic [XLEN-1:0] src_a;
  logic [XLEN-1:0] src_b;
  logic [XLEN-1:0] alu_res;
  logic            zero;
  logic            less;
  logic            taken;
  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] jalr_sum;
  logic [XLEN-1:0] nextpc;
  logic [XLEN-1:0] load_data;
  logic [XLEN-1:0] wdata;
  ex_res_t         res_d;
  ex_res_t         res_q;
  logic            valid_q;

  assign ctrl  = i_req.ctrl;
  assign o_rs1 = i_req.rs1;
  assign o_rs2 = i_req.rs2;

  assign src_a = ctrl.src_a_pc ? i_req.pc : i_rs1_data;

  always_comb begin
    case (ctrl.src_b)
      srcb_rs2: src_b = i_rs2_data;
      srcb_imm: src_b = i_req.imm;
      default:  src_b = XLEN'(4);
    endcase
  end

  exu_alu alu_i (
    .i_op       (ctrl.alu_op),
    .i_word_cut (ctrl.word_cut),
    .i_src_a    (src_a),
    .i_src_b    (src_b),
    .i_imm      (i_req.imm),
    .o_result   (alu_res),
    .o_zero     (zero),
    .o_less     (less)
  );

  always_comb begin
    case (ctrl.branch)
      br_jal, br_jalr: taken = 1'b1;
      br_beq:          taken = zero;
      br_bne:          taken = !zero;
      br_blt:          taken = less;
      br_bge:          taken = !less;
      default:         taken = 1'b0;
    endcase
  end

  assign pc_plus4 = i_req.pc + XLEN'(4);
  assign jalr_sum = i_rs1_data + i_req.imm;
  assign nextpc   = (ctrl.branch == br_jalr) ? {jalr_sum[XLEN-1:1], 1'b0} :
                    taken ? i_req.pc + i_req.imm : pc_plus4;

  always_comb begin
    case (ctrl.mem_op)
      mem_lb:  load_data = {{(XLEN-8){i_req.rdata[7]}}, i_req.rdata[7:0]};
      mem_lbu: load_data = {{(XLEN-8){1'b0}}, i_req.rdata[7:0]};
      mem_lh:  load_data = {{(XLEN-16){i_req.rdata[15]}}, i_req.rdata[15:0]};
      mem_lhu: load_data = {{(XLEN-16){1'b0}}, i_req.rdata[15:0]};
      mem_lw:  load_data = {{(XLEN-32){i_req.rdata[31]}}, i_req.rdata[31:0]};
      mem_lwu: load_data = {{(XLEN-32){1'b0}}, i_req.rdata[31:0]};
      default: load_data = i_req.rdata;
    endcase
  end

  // loads take memory data, jumps get pc+4 from the ALU
  assign wdata = (ctrl.mem_op != mem_none) ? load_data : alu_res;

  assign res_d = '{
    valid:     i_req.valid,
    pc:        i_req.pc,
    nextpc:    nextpc,
    rd:        i_req.rd,
    reg_write: ctrl.reg_write,
    wdata:     wdata,
    illegal:   ctrl.illegal
  };

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= i_req.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_req.valid) begin
      res_q <= res_d;
    end
  end

  always_comb begin
    o_res       = res_q;
    o_res.valid = valid_q;
  end

  a_branch_or_load: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_req.valid |-> !(ctrl.branch != br_none && ctrl.mem_op != mem_none));

endmodule

// ==== exu/exu_alu.sv ====
// integer ALU: add/sub, logic, shifts, compares, mul/div/rem with word cut
`timescale 1ns/10ps
module exu_alu (
  input  exec_pkg::alu_op_e         i_op,
  input  logic                      i_word_cut,
  input  logic [exec_pkg::XLEN-1:0] i_src_a,
  input  logic [exec_pkg::XLEN-1:0] i_src_b,
  input  logic [exec_pkg::XLEN-1:0] i_imm,
  output logic [exec_pkg::XLEN-1:0] o_result,
  output logic                      o_zero,
  output logic                      o_less
);
  import exec_pkg::*;

  logic [XLEN-1:0] a;
  logic [XLEN-1:0] b;
  logic [XLEN-1:0] sa;
  logic [XLEN-1:0] sb;
  logic [5:0]      shamt;
  logic [XLEN-1:0] diff;
  logic [XLEN-1:0] quot_s;
  logic [XLEN-1:0] rem_s;
  logic [XLEN-1:0] sra_res;
  logic            div_ovf;
  logic            slt;
  logic            ult;
  logic [XLEN-1:0] res;

  // word forms work on the low half, zero extended
  assign a = i_word_cut ? {{(XLEN-32){1'b0}}, i_src_a[31:0]} : i_src_a;
  assign b = i_word_cut ? {{(XLEN-32){1'b0}}, i_src_b[31:0]} : i_src_b;
  // signed divide and sra need the low half sign extended instead
  assign sa = i_word_cut ? {{(XLEN-32){i_src_a[31]}}, i_src_a[31:0]} : i_src_a;
  assign sb = i_word_cut ? {{(XLEN-32){i_src_b[31]}}, i_src_b[31:0]} : i_src_b;

  assign shamt   = i_word_cut ? {1'b0, i_src_b[4:0]} : i_src_b[5:0];
  assign diff    = a - b;
  assign slt     = $signed(a) < $signed(b);
  assign ult     = a < b;
  assign quot_s  = $signed(sa) / $signed(sb);
  assign rem_s   = $signed(sa) % $signed(sb);
  assign sra_res = $signed(sa) >>> shamt;
  // most negative divided by -1
  assign div_ovf = (sa == {1'b1, {(XLEN-1){1'b0}}}) && (sb == '1);

  assign o_zero = (diff == '0);
  assign o_less = (i_op == alu_sltu) ? ult : slt;

  always_comb begin
    case (i_op)
      alu_add:  res = a + b;
      alu_sub:  res = diff;
      alu_slt:  res = {{(XLEN-1){1'b0}}, slt};
      alu_sltu: res = {{(XLEN-1){1'b0}}, ult};
      alu_xor:  res = a ^ b;
      alu_and:  res = a & b;
      alu_or:   res = a | b;
      alu_sll:  res = a << shamt;
      alu_srl:  res = a >> shamt;
      alu_sra:  res = sra_res;
      alu_mul:  res = a * b;
      alu_div:  res = (sb == '0) ? '1 : (div_ovf ? sa : quot_s);
      alu_divu: res = (b == '0) ? '1 : a / b;
      alu_rem:  res = (sb == '0) ? sa : (div_ovf ? '0 : rem_s);
      alu_remu: res = (b == '0) ? a : a % b;
      default:  res = i_imm;
    endcase
  end

  assign o_result = i_word_cut ? {{(XLEN-32){res[31]}}, res[31:0]} : res;

endmodule

// ==== hdl/gpr_file.sv ====
// integer register file, x0 hardwired to zero, write-first read bypass
`timescale 1ns/10ps
module gpr_file (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic [exec_pkg::REG_AW-1:0] i_rs1,
  input  logic [exec_pkg::REG_AW-1:0] i_rs2,
  output logic [exec_pkg::XLEN-1:0]   o_rs1_data,
  output logic [exec_pkg::XLEN-1:0]   o_rs2_data,
  input  logic                        i_we,
  input  logic [exec_pkg::REG_AW-1:0] i_wa,
  input  logic [exec_pkg::XLEN-1:0]   i_wd
);
  import exec_pkg::*;

  logic [XLEN-1:0] regs [1:NUM_REGS-1];
  logic            wr_en;

  assign wr_en = i_we && (i_wa != '0);

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[i_wa] <= i_wd;
    end
  end

  // commit in the same cycle wins over the stored value
  assign o_rs1_data = (i_rs1 == '0) ? '0 : (wr_en && i_wa == i_rs1) ? i_wd : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : (wr_en && i_wa == i_rs2) ? i_wd : regs[i_rs2];

  a_no_x0_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_we |-> (i_wa != '0));

endmodule

// ==== idu/idu_decode.sv ====
// instruction decoder: control fields, immediates and the request register
`timescale 1ns/10ps
module idu_decode (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  logic                      i_valid,
  input  logic [exec_pkg::ILEN-1:0] i_inst,
  input  logic [exec_pkg::XLEN-1:0] i_pc,
  input  logic [exec_pkg::XLEN-1:0] i_rdata,
  output exec_pkg::dec_req_t        o_req
);
  import exec_pkg::*;

  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic            is_reg;
  logic            is_word;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm;
  ctrl_t           ctrl;
  dec_req_t        req_d;
  dec_req_t        req_q;
  logic            valid_q;

  assign opcode  = opcode_e'(i_inst[6:0]);
  assign funct3  = i_inst[14:12];
  // bit 5 picks register forms, bit 3 the 32-bit forms
  assign is_reg  = i_inst[5];
  assign is_word = i_inst[3];

  assign imm_i = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_b = {{(XLEN-12){i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{(XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(XLEN-20){i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  // bit 25 is shamt[5] in 64-bit immediate shifts
  always_comb begin
    funct7 = i_inst[31:25];
    if (!is_reg && !is_word) begin
      funct7[0] = 1'b0;
    end
  end

  always_comb begin
    ctrl           = '0;
    ctrl.alu_op    = alu_add;
    ctrl.branch    = br_none;
    ctrl.mem_op    = mem_none;
    ctrl.src_b     = srcb_imm;
    ctrl.reg_write = 1'b1;
    imm            = imm_i;
    case (opcode)
      opc_lui: begin
        ctrl.alu_op = alu_copy;
        imm         = imm_u;
      end
      opc_auipc: begin
        ctrl.src_a_pc = 1'b1;
        imm           = imm_u;
      end
      opc_jal: begin
        // link value pc+4 comes from the ALU
        ctrl.branch   = br_jal;
        ctrl.src_a_pc = 1'b1;
        ctrl.src_b    = srcb_four;
        imm           = imm_j;
      end
      opc_jalr: begin
        ctrl.branch   = br_jalr;
        ctrl.src_a_pc = 1'b1;
        ctrl.src_b    = srcb_four;
        ctrl.illegal  = (funct3 != 3'b000);
      end
      opc_branch: begin
        imm            = imm_b;
        ctrl.src_b     = srcb_rs2;
        ctrl.reg_write = 1'b0;
        // bltu/bgeu share blt/bge with the unsigned compare
        if (funct3[1]) begin
          ctrl.alu_op = alu_sltu;
        end else begin
          ctrl.alu_op = alu_slt;
        end
        case (funct3)
          3'b000:         ctrl.branch = br_beq;
          3'b001:         ctrl.branch = br_bne;
          3'b100, 3'b110: ctrl.branch = br_blt;
          3'b101, 3'b111: ctrl.branch = br_bge;
          default:        ctrl.illegal = 1'b1;
        endcase
      end
      opc_load: begin
        case (funct3)
          3'b000:  ctrl.mem_op = mem_lb;
          3'b001:  ctrl.mem_op = mem_lh;
          3'b010:  ctrl.mem_op = mem_lw;
          3'b011:  ctrl.mem_op = mem_ld;
          3'b100:  ctrl.mem_op = mem_lbu;
          3'b101:  ctrl.mem_op = mem_lhu;
          3'b110:  ctrl.mem_op = mem_lwu;
          default: ctrl.illegal = 1'b1;
        endcase
      end
      opc_op_imm, opc_op_imm_32, opc_op, opc_op_32: begin
        ctrl.word_cut = is_word;
        if (is_reg) begin
          ctrl.src_b = srcb_rs2;
        end
        if (is_reg && funct7 == 7'b0000001) begin
          // M extension, mulh variants not supported
          case (funct3)
            3'b000:  ctrl.alu_op = alu_mul;
            3'b100:  ctrl.alu_op = alu_div;
            3'b101:  ctrl.alu_op = alu_divu;
            3'b110:  ctrl.alu_op = alu_rem;
            3'b111:  ctrl.alu_op = alu_remu;
            default: ctrl.illegal = 1'b1;
          endcase
        end else begin
          case (funct3)
            3'b000:  ctrl.alu_op = (is_reg && funct7[5]) ? alu_sub : alu_add;
            3'b001:  ctrl.alu_op = alu_sll;
            3'b010:  ctrl.alu_op = alu_slt;
            3'b011:  ctrl.alu_op = alu_sltu;
            3'b100:  ctrl.alu_op = alu_xor;
            3'b101:  ctrl.alu_op = funct7[5] ? alu_sra : alu_srl;
            3'b110:  ctrl.alu_op = alu_or;
            default: ctrl.alu_op = alu_and;
          endcase
          if (is_reg || funct3 == 3'b001 || funct3 == 3'b101) begin
            if ({funct7[6], funct7[4:0]} != '0) begin
              ctrl.illegal = 1'b1;
            end
            if (funct7[5] && funct3 != 3'b101 && !(funct3 == 3'b000 && is_reg)) begin
              ctrl.illegal = 1'b1;
            end
          end
          if (is_word && funct3 != 3'b000 && funct3 != 3'b001 && funct3 != 3'b101) begin
            ctrl.illegal = 1'b1;
          end
        end
      end
      default: ctrl.illegal = 1'b1;
    endcase
    // an illegal instruction retires with no side effects
    if (ctrl.illegal) begin
      ctrl.reg_write = 1'b0;
      ctrl.branch    = br_none;
      ctrl.mem_op    = mem_none;
    end
  end

  assign req_d = '{
    valid: i_valid,
    pc:    i_pc,
    imm:   imm,
    rs1:   i_inst[19:15],
    rs2:   i_inst[24:20],
    rd:    i_inst[11:7],
    rdata: i_rdata,
    ctrl:  ctrl
  };

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      req_q <= req_d;
    end
  end

  always_comb begin
    o_req       = req_q;
    o_req.valid = valid_q;
  end

  a_alu_op_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_req.valid |-> (!$isunknown(o_req.ctrl.alu_op) &&
                     int'(o_req.ctrl.alu_op) < ALU_OP_CNT));

endmodule

// ==== common/exec_pkg.sv ====
// execute path widths, opcode and control enums, pipeline stage structs
package exec_pkg;

  localparam int XLEN       = 64;
  localparam int ILEN       = 32;
  localparam int REG_AW     = 5;
  localparam int NUM_REGS   = 32;
  localparam int ALU_OP_CNT = 16;

  // RV64 major opcodes handled by the decoder
  typedef enum logic [6:0] {
    opc_load      = 7'b0000011,
    opc_op_imm    = 7'b0010011,
    opc_auipc     = 7'b0010111,
    opc_op_imm_32 = 7'b0011011,
    opc_op        = 7'b0110011,
    opc_lui       = 7'b0110111,
    opc_op_32     = 7'b0111011,
    opc_branch    = 7'b1100011,
    opc_jalr      = 7'b1100111,
    opc_jal       = 7'b1101111
  } opcode_e;

  typedef enum logic [4:0] {
    alu_add  = 5'd0,
    alu_sub  = 5'd1,
    alu_slt  = 5'd2,
    alu_sltu = 5'd3,
    alu_xor  = 5'd4,
    alu_and  = 5'd5,
    alu_or   = 5'd6,
    alu_sll  = 5'd7,
    alu_srl  = 5'd8,
    alu_sra  = 5'd9,
    alu_mul  = 5'd10,
    alu_div  = 5'd11,
    alu_divu = 5'd12,
    alu_rem  = 5'd13,
    alu_remu = 5'd14,
    alu_copy = 5'd15
  } alu_op_e;

  typedef enum logic [2:0] {
    br_none = 3'b000,
    br_jal  = 3'b001,
    br_jalr = 3'b010,
    br_beq  = 3'b100,
    br_bne  = 3'b101,
    br_blt  = 3'b110,
    br_bge  = 3'b111
  } branch_e;

  typedef enum logic [2:0] {
    mem_lb, mem_lbu, mem_lh, mem_lhu, mem_lw, mem_lwu, mem_ld, mem_none
  } mem_op_e;

  typedef enum logic [1:0] {
    srcb_rs2, srcb_imm, srcb_four
  } src_b_e;

  typedef struct packed {
    alu_op_e alu_op;
    branch_e branch;
    mem_op_e mem_op;
    src_b_e  src_b;
    logic    src_a_pc;
    logic    word_cut;
    logic    reg_write;
    logic    illegal;
  } ctrl_t;

  typedef struct packed {
    logic              valid;
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   imm;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   rdata;
    ctrl_t             ctrl;
  } dec_req_t;

  typedef struct packed {
    logic              valid;
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   nextpc;
    logic [REG_AW-1:0] rd;
    logic              reg_write;
    logic [XLEN-1:0]   wdata;
    logic              illegal;
  } ex_res_t;

  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   nextpc;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   wdata;
    logic              reg_write;
    logic              illegal;
  } commit_t;

endpackage
